// ==== verilog/core_data_pkg.sv ====
package core_data_pkg;

    ////////////////////////////////////////////////////////////
    // Bus widths
    ////////////////////////////////////////////////////////////

    // Byte address, data word and byte enables
    localparam int ADDR_W = 32;
    localparam int DATA_W = 32;
    localparam int BE_W   = 4;

    typedef logic [ADDR_W-1:0] addr_t;
    typedef logic [DATA_W-1:0] data_t;
    typedef logic [BE_W-1:0]   be_t;

    ////////////////////////////////////////////////////////////
    // Address map
    ////////////////////////////////////////////////////////////

    // Local SRAM window starts here
    localparam addr_t SRAM_BASE = 32'h0000_0000;

    ////////////////////////////////////////////////////////////
    // Arbiter
    ////////////////////////////////////////////////////////////

    // Owner of the data memory for one transfer
    typedef enum logic {
        PORT_CORE = 1'b0,
        PORT_EXT  = 1'b1
    } port_e;

endpackage

// ==== verilog/mem_req_if.sv ====
`timescale 1ns/1ps

// Request and response signals of the core-side memory protocol
interface mem_req_if;

    // Request side
    logic                  req;
    logic                  we;
    core_data_pkg::addr_t  addr;
    core_data_pkg::be_t    be;
    core_data_pkg::data_t  wdata;

    // Response side
    logic                  gnt;
    logic                  rvalid;
    core_data_pkg::data_t  rdata;

    modport requester (
        output req,
        output we,
        output addr,
        output be,
        output wdata,
        input  gnt,
        input  rvalid,
        input  rdata
    );

    modport responder (
        input  req,
        input  we,
        input  addr,
        input  be,
        input  wdata,
        output gnt,
        output rvalid,
        output rdata
    );

endinterface

// ==== verilog/core_req_slot.sv ====
`timescale 1ns/1ps

module core_req_slot #(
    parameter int MEM_SIZE_KB = 8
) (
    input  logic                  clk_i,
    input  logic                  reset_ni,

    input  logic                  core_req_i,
    input  logic                  core_we_i,
    input  core_data_pkg::addr_t  core_addr_i,
    input  core_data_pkg::be_t    core_be_i,
    input  core_data_pkg::data_t  core_wdata_i,
    output logic                  core_gnt_o,
    output logic                  core_rvalid_o,
    output core_data_pkg::data_t  core_rdata_o,

    mem_req_if.requester          mem,

    output logic                  bus_req_o,
    output logic                  bus_we_o,
    output core_data_pkg::addr_t  bus_addr_o,
    output core_data_pkg::be_t    bus_be_o,
    output core_data_pkg::data_t  bus_wdata_o,
    input  logic                  bus_gnt_i,
    input  logic                  bus_rvalid_i,
    input  core_data_pkg::data_t  bus_rdata_i
);

    localparam core_data_pkg::addr_t WINDOW_BYTES =
        core_data_pkg::addr_t'(MEM_SIZE_KB * 1024);

    logic                  valid_q;
    logic                  issued_q;
    logic                  to_bus_q;
    logic                  we_q;
    core_data_pkg::addr_t  addr_q;
    core_data_pkg::be_t    be_q;
    core_data_pkg::data_t  wdata_q;

    core_data_pkg::addr_t  offset;
    logic                  to_bus;
    logic                  present;
    logic                  target_gnt;
    logic                  done;

    ////////////////////////////////////////////////////////////
    // Address decode
    ////////////////////////////////////////////////////////////

    // Below the base wraps to a large offset, so one compare covers both ends
    assign offset = core_addr_i - core_data_pkg::SRAM_BASE;
    assign to_bus = (offset >= WINDOW_BYTES);

    ////////////////////////////////////////////////////////////
    // Request steering
    ////////////////////////////////////////////////////////////

    assign present    = valid_q & ~issued_q;
    assign target_gnt = to_bus_q ? bus_gnt_i : mem.gnt;

    assign mem.req    = present & ~to_bus_q;
    assign mem.we     = we_q;
    assign mem.addr   = addr_q;
    assign mem.be     = be_q;
    assign mem.wdata  = wdata_q;

    assign bus_req_o   = present & to_bus_q;
    assign bus_we_o    = we_q;
    assign bus_addr_o  = addr_q;
    assign bus_be_o    = be_q;
    assign bus_wdata_o = wdata_q;

    // Response of the selected target closes the slot
    assign done = valid_q & issued_q & (to_bus_q ? bus_rvalid_i : mem.rvalid);

    assign core_gnt_o    = ~valid_q | done;
    assign core_rvalid_o = done;
    assign core_rdata_o  = to_bus_q ? bus_rdata_i : mem.rdata;

    always_ff @(posedge clk_i or negedge reset_ni) begin
        if (!reset_ni) begin
            valid_q  <= 1'b0;
            issued_q <= 1'b0;
            to_bus_q <= 1'b0;
        end else if (core_req_i && core_gnt_o) begin
            valid_q  <= 1'b1;
            issued_q <= 1'b0;
            to_bus_q <= to_bus;
        end else if (done) begin
            valid_q  <= 1'b0;
        end else if (present && target_gnt) begin
            issued_q <= 1'b1;
        end
    end

    // Request fields
    always_ff @(posedge clk_i) begin
        if (core_req_i && core_gnt_o) begin
            we_q    <= core_we_i;
            addr_q  <= core_addr_i;
            be_q    <= core_be_i;
            wdata_q <= core_wdata_i;
        end
    end

endmodule

// ==== verilog/sram_arbiter.sv ====
`timescale 1ns/1ps

module sram_arbiter (
    input  logic          clk_i,
    input  logic          reset_ni,

    mem_req_if.responder  core_port,
    mem_req_if.responder  ext_port,
    mem_req_if.requester  mem
);

    core_data_pkg::port_e sel;
    core_data_pkg::port_e last_q;
    core_data_pkg::port_e owner_q;

    ////////////////////////////////////////////////////////////
    // Round-robin select
    ////////////////////////////////////////////////////////////

    always_comb begin
        if (core_port.req && ext_port.req) begin
            // Loser of the last round goes first
            sel = (last_q == core_data_pkg::PORT_CORE) ? core_data_pkg::PORT_EXT
                                                       : core_data_pkg::PORT_CORE;
        end else if (ext_port.req) begin
            sel = core_data_pkg::PORT_EXT;
        end else begin
            sel = core_data_pkg::PORT_CORE;
        end
    end

    always_comb begin
        mem.req = core_port.req | ext_port.req;
        if (sel == core_data_pkg::PORT_EXT) begin
            mem.we    = ext_port.we;
            mem.addr  = ext_port.addr;
            mem.be    = ext_port.be;
            mem.wdata = ext_port.wdata;
        end else begin
            mem.we    = core_port.we;
            mem.addr  = core_port.addr;
            mem.be    = core_port.be;
            mem.wdata = core_port.wdata;
        end
    end

    assign core_port.gnt = mem.gnt & (sel == core_data_pkg::PORT_CORE);
    assign ext_port.gnt  = mem.gnt & (sel == core_data_pkg::PORT_EXT);

    ////////////////////////////////////////////////////////////
    // Response return
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clk_i or negedge reset_ni) begin
        if (!reset_ni) begin
            last_q  <= core_data_pkg::PORT_EXT;
            owner_q <= core_data_pkg::PORT_CORE;
        end else if (mem.req && mem.gnt) begin
            last_q  <= sel;
            owner_q <= sel;
        end
    end

    assign core_port.rvalid = mem.rvalid & (owner_q == core_data_pkg::PORT_CORE);
    assign ext_port.rvalid  = mem.rvalid & (owner_q == core_data_pkg::PORT_EXT);
    assign core_port.rdata  = mem.rdata;
    assign ext_port.rdata   = mem.rdata;

endmodule

// ==== verilog/data_memory.sv ====
`timescale 1ns/1ps

module data_memory #(
    parameter int MEM_SIZE_KB = 8
) (
    input  logic          clk_i,
    input  logic          reset_ni,

    mem_req_if.responder  port
);

    // 256 words of 32 bits per KB
    localparam int DEPTH = MEM_SIZE_KB * 256;
    localparam int IDX_W = $clog2(DEPTH);

    core_data_pkg::data_t mem_q [DEPTH];
    core_data_pkg::data_t rdata_q;
    logic                 rvalid_q;

    core_data_pkg::addr_t offset;
    logic [IDX_W-1:0]     idx;

    assign offset = port.addr - core_data_pkg::SRAM_BASE;
    assign idx    = offset[IDX_W+1:2];

    // Always ready
    assign port.gnt = port.req;

    always_ff @(posedge clk_i) begin
        if (port.req) begin
            if (port.we) begin
                for (int i = 0; i < core_data_pkg::BE_W; i++) begin
                    if (port.be[i]) begin
                        mem_q[idx][8*i +: 8] <= port.wdata[8*i +: 8];
                    end
                end
            end else begin
                rdata_q <= mem_q[idx];
            end
        end
    end

    always_ff @(posedge clk_i or negedge reset_ni) begin
        if (!reset_ni) begin
            rvalid_q <= 1'b0;
        end else begin
            rvalid_q <= port.req;
        end
    end

    assign port.rvalid = rvalid_q;
    assign port.rdata  = rdata_q;

endmodule

// ==== verilog/core_data_top.sv ====
`timescale 1ns/1ps

module core_data_top #(
    parameter int MEM_SIZE_KB = 8
) (
    input  logic                  clk_i,
    input  logic                  reset_ni,

    input  logic                  core_req_i,
    input  logic                  core_we_i,
    input  core_data_pkg::addr_t  core_addr_i,
    input  core_data_pkg::be_t    core_be_i,
    input  core_data_pkg::data_t  core_wdata_i,
    output logic                  core_gnt_o,
    output logic                  core_rvalid_o,
    output core_data_pkg::data_t  core_rdata_o,

    output logic                  bus_req_o,
    output logic                  bus_we_o,
    output core_data_pkg::addr_t  bus_addr_o,
    output core_data_pkg::be_t    bus_be_o,
    output core_data_pkg::data_t  bus_wdata_o,
    input  logic                  bus_gnt_i,
    input  logic                  bus_rvalid_i,
    input  core_data_pkg::data_t  bus_rdata_i,

    input  logic                  ext_req_i,
    input  logic                  ext_we_i,
    input  core_data_pkg::addr_t  ext_addr_i,
    input  core_data_pkg::be_t    ext_be_i,
    input  core_data_pkg::data_t  ext_wdata_i,
    output logic                  ext_gnt_o,
    output logic                  ext_rvalid_o,
    output core_data_pkg::data_t  ext_rdata_o
);

    mem_req_if core_mem ();
    mem_req_if ext_mem ();
    mem_req_if sram ();

    ////////////////////////////////////////////////////////////
    // External access port
    ////////////////////////////////////////////////////////////

    assign ext_mem.req   = ext_req_i;
    assign ext_mem.we    = ext_we_i;
    assign ext_mem.addr  = ext_addr_i;
    assign ext_mem.be    = ext_be_i;
    assign ext_mem.wdata = ext_wdata_i;
    assign ext_gnt_o     = ext_mem.gnt;
    assign ext_rvalid_o  = ext_mem.rvalid;
    assign ext_rdata_o   = ext_mem.rdata;

    ////////////////////////////////////////////////////////////
    // Instances
    ////////////////////////////////////////////////////////////

    core_req_slot #(
        .MEM_SIZE_KB   (MEM_SIZE_KB)
    ) u_req_slot (
        .clk_i         (clk_i),
        .reset_ni      (reset_ni),
        .core_req_i    (core_req_i),
        .core_we_i     (core_we_i),
        .core_addr_i   (core_addr_i),
        .core_be_i     (core_be_i),
        .core_wdata_i  (core_wdata_i),
        .core_gnt_o    (core_gnt_o),
        .core_rvalid_o (core_rvalid_o),
        .core_rdata_o  (core_rdata_o),
        .mem           (core_mem.requester),
        .bus_req_o     (bus_req_o),
        .bus_we_o      (bus_we_o),
        .bus_addr_o    (bus_addr_o),
        .bus_be_o      (bus_be_o),
        .bus_wdata_o   (bus_wdata_o),
        .bus_gnt_i     (bus_gnt_i),
        .bus_rvalid_i  (bus_rvalid_i),
        .bus_rdata_i   (bus_rdata_i)
    );

    sram_arbiter u_arbiter (
        .clk_i         (clk_i),
        .reset_ni      (reset_ni),
        .core_port     (core_mem.responder),
        .ext_port      (ext_mem.responder),
        .mem           (sram.requester)
    );

    data_memory #(
        .MEM_SIZE_KB   (MEM_SIZE_KB)
    ) u_data_memory (
        .clk_i         (clk_i),
        .reset_ni      (reset_ni),
        .port          (sram.responder)
    );

endmodule

// ==== bench/tb_core_data_top.sv ====
`timescale 1ns/1ps

module tb_core_data_top;

    localparam int MEM_SIZE_KB = 8;
    localparam int WORDS       = MEM_SIZE_KB * 256;
    localparam int T2_N        = 16;
    localparam int T3_N        = 12;
    localparam int T4_N        = 8;
    localparam int T5_N        = 8;
    localparam int N_OPS       = 3 * T2_N + T3_N + 4 * T4_N + 4 * T5_N;
    localparam logic [31:0] WINDOW_END = 32'(MEM_SIZE_KB * 1024);
    localparam logic [31:0] BUS_BASE   = 32'h4000_0000;
    localparam logic [31:0] BUS_XOR    = 32'h5a5a_5a5a;

    logic        clk_i;
    logic        reset_ni;
    logic        core_req_i, core_we_i;
    logic [31:0] core_addr_i, core_wdata_i;
    logic [3:0]  core_be_i;
    logic        core_gnt_o, core_rvalid_o;
    logic [31:0] core_rdata_o;
    logic        bus_req_o, bus_we_o;
    logic [31:0] bus_addr_o, bus_wdata_o;
    logic [3:0]  bus_be_o;
    logic        bus_gnt_i, bus_rvalid_i;
    logic [31:0] bus_rdata_i;
    logic        ext_req_i, ext_we_i;
    logic [31:0] ext_addr_i, ext_wdata_i;
    logic [3:0]  ext_be_i;
    logic        ext_gnt_o, ext_rvalid_o;
    logic [31:0] ext_rdata_o;

    logic [31:0] lfsr_q = 32'ha06b2c9f;
    logic [31:0] shadow [WORDS];
    // Check flag and expected read data of each outstanding response
    logic [32:0] core_exp_q [$];
    logic [32:0] ext_exp_q [$];
    // we, be, addr and wdata of each expected bus request
    logic [68:0] bus_exp_q [$];
    int          errors = 0;
    int          checks = 0;
    int          core_wait = 0;
    int          ext_wait = 0;
    logic        ext_granted_q = 1'b0;
    logic        last_ext_q = 1'b0;
    logic        win_seen_q = 1'b0;

    core_data_top #(
        .MEM_SIZE_KB (MEM_SIZE_KB)
    ) UUT (.*);

    initial begin
        clk_i = 1'b0;
        forever #4 clk_i = ~clk_i;
    end

    ////////////////////////////////////////////////////////////
    // Random numbers and reference model
    ////////////////////////////////////////////////////////////

    // Fibonacci LFSR with taps 32 22 2 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    task automatic take_bits(input int n, output logic [31:0] v);
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_q = lfsr_next(lfsr_q);
            v = {v[30:0], lfsr_q[0]};
        end
    endtask

    // Word read back after wdata lands on old under the byte enables
    function automatic logic [31:0] expected_read(input logic [31:0] old,
                                                  input logic [31:0] wdata,
                                                  input logic [3:0] be);
        logic [31:0] word;
        word = old;
        for (int b = 0; b < 4; b++) begin
            if (be[b]) begin
                word[8*b +: 8] = wdata[8*b +: 8];
            end
        end
        return word;
    endfunction

    function automatic logic [32:0] model_access(input logic we, input logic [31:0] addr,
                                                 input logic [3:0] be,
                                                 input logic [31:0] wdata);
        int idx;
        idx = int'(addr[31:2]) % WORDS;
        if (we) begin
            shadow[idx] = expected_read(shadow[idx], wdata, be);
            return {1'b0, 32'h0};
        end
        return {1'b1, shadow[idx]};
    endfunction

    task automatic check_value(input string name, input logic [31:0] exp,
                               input logic [31:0] act);
        checks++;
        if (exp !== act) begin
            errors++;
            $display("Mismatch at %0d ns: %s expected %h, got %h", $time, name, exp, act);
        end
    endtask

    ////////////////////////////////////////////////////////////
    // Port drivers
    ////////////////////////////////////////////////////////////

    // Starts and returns 1 ns after a rising edge, once the request was taken
    task automatic core_access(input logic we, input logic [31:0] addr,
                               input logic [3:0] be, input logic [31:0] wdata);
        if (addr >= WINDOW_END) begin
            bus_exp_q.push_back({we, be, addr, wdata});
            core_exp_q.push_back({~we, addr ^ BUS_XOR});
        end else begin
            core_exp_q.push_back(model_access(we, addr, be, wdata));
        end
        core_req_i   = 1'b1;
        core_we_i    = we;
        core_addr_i  = addr;
        core_be_i    = be;
        core_wdata_i = wdata;
        do begin
            @(negedge clk_i);
        end while (!core_gnt_o);
        @(posedge clk_i);
        #1;
        core_req_i = 1'b0;
    endtask

    task automatic ext_access(input logic we, input logic [31:0] addr,
                              input logic [3:0] be, input logic [31:0] wdata);
        ext_exp_q.push_back(model_access(we, addr, be, wdata));
        ext_req_i   = 1'b1;
        ext_we_i    = we;
        ext_addr_i  = addr;
        ext_be_i    = be;
        ext_wdata_i = wdata;
        do begin
            @(negedge clk_i);
        end while (!ext_gnt_o);
        @(posedge clk_i);
        #1;
        ext_req_i = 1'b0;
    endtask

    task automatic wait_idle();
        while (core_exp_q.size() != 0 || ext_exp_q.size() != 0) begin
            @(posedge clk_i);
            #1;
        end
    endtask

    task automatic end_test(input string name, input int mark);
        $display("%s: %0d errors", name, errors - mark);
    endtask

    ////////////////////////////////////////////////////////////
    // Response checks
    ////////////////////////////////////////////////////////////

    always @(negedge clk_i) begin : response_monitor
        logic [32:0] entry;
        if (reset_ni) begin
            if (core_rvalid_o) begin
                if (core_exp_q.size() == 0) begin
                    errors++;
                    $display("Error at %0d ns: core response with no request", $time);
                end else begin
                    entry = core_exp_q.pop_front();
                    if (entry[32]) begin
                        check_value("core_rdata_o", entry[31:0], core_rdata_o);
                    end
                end
            end
            if (ext_rvalid_o) begin
                if (ext_exp_q.size() == 0) begin
                    errors++;
                    $display("Error at %0d ns: access port response with no request", $time);
                end else begin
                    entry = ext_exp_q.pop_front();
                    if (entry[32]) begin
                        check_value("ext_rdata_o", entry[31:0], ext_rdata_o);
                    end
                end
            end
            // rvalid exactly one cycle after a grant
            if (ext_granted_q || ext_rvalid_o) begin
                check_value("ext_rvalid_o", 32'(ext_granted_q), 32'(ext_rvalid_o));
            end
            ext_granted_q = ext_req_i & ext_gnt_o;
            // A waiting port must win the next round
            core_wait = (UUT.core_mem.req && !UUT.core_mem.gnt) ? core_wait + 1 : 0;
            ext_wait  = (ext_req_i && !ext_gnt_o) ? ext_wait + 1 : 0;
            if (core_wait > 1 || ext_wait > 1) begin
                errors++;
                $display("Error at %0d ns: a port lost the SRAM twice in a row", $time);
            end
            // Both requesting, the last winner yields
            if (UUT.core_mem.req && ext_req_i && win_seen_q) begin
                check_value("ext_gnt_o", 32'(!last_ext_q), 32'(ext_gnt_o));
            end
            if (ext_req_i && ext_gnt_o) begin
                last_ext_q = 1'b1;
                win_seen_q = 1'b1;
            end else if (UUT.core_mem.req && UUT.core_mem.gnt) begin
                last_ext_q = 1'b0;
                win_seen_q = 1'b1;
            end
        end
    end

    // Bus slave with random grant delay and response latency
    initial begin : bus_model
        logic [31:0] wait_n;
        logic [31:0] lat_n;
        logic [68:0] req_exp;
        logic [31:0] addr;
        bus_gnt_i    = 1'b0;
        bus_rvalid_i = 1'b0;
        bus_rdata_i  = '0;
        forever begin
            @(negedge clk_i);
            if (bus_req_o) begin
                req_exp = '0;
                if (bus_exp_q.size() == 0) begin
                    errors++;
                    $display("Error at %0d ns: bus request the core never issued", $time);
                end else begin
                    req_exp = bus_exp_q.pop_front();
                end
                check_value("bus_we_o", 32'(req_exp[68]), 32'(bus_we_o));
                check_value("bus_be_o", 32'(req_exp[67:64]), 32'(bus_be_o));
                check_value("bus_addr_o", req_exp[63:32], bus_addr_o);
                check_value("bus_wdata_o", req_exp[31:0], bus_wdata_o);
                check_value("core_gnt_o", 32'd0, 32'(core_gnt_o));
                addr = bus_addr_o;
                take_bits(2, wait_n);
                take_bits(2, lat_n);
                repeat (wait_n) begin
                    @(negedge clk_i);
                    check_value("core_gnt_o", 32'd0, 32'(core_gnt_o));
                    check_value("bus_req_o", 32'd1, 32'(bus_req_o));
                end
                @(posedge clk_i);
                #1;
                bus_gnt_i = 1'b1;
                @(posedge clk_i);
                #1;
                bus_gnt_i = 1'b0;
                // Granted request is not presented again
                check_value("bus_req_o", 32'd0, 32'(bus_req_o));
                repeat (lat_n % 3) begin
                    @(posedge clk_i);
                    #1;
                end
                bus_rvalid_i = 1'b1;
                bus_rdata_i  = addr ^ BUS_XOR;
                @(posedge clk_i);
                #1;
                bus_rvalid_i = 1'b0;
            end
        end
    end

    initial begin : watchdog
        repeat (N_OPS * 40) @(posedge clk_i);
        $display("Timeout: the tests did not finish within %0d cycles", N_OPS * 40);
        $display("TEST FAILED");
        $finish;
    end

    ////////////////////////////////////////////////////////////
    // Tests
    ////////////////////////////////////////////////////////////

    initial begin : main
        logic [31:0] a;
        logic [31:0] d;
        logic [31:0] bmask;
        logic [31:0] r;
        int          mark;
        reset_ni     = 1'b0;
        core_req_i   = 1'b0;
        core_we_i    = 1'b0;
        core_addr_i  = '0;
        core_be_i    = '0;
        core_wdata_i = '0;
        ext_req_i    = 1'b0;
        ext_we_i     = 1'b0;
        ext_addr_i   = '0;
        ext_be_i     = '0;
        ext_wdata_i  = '0;
        repeat (10) @(posedge clk_i);
        #1;
        reset_ni = 1'b1;

        mark = errors;
        @(negedge clk_i);
        check_value("core_gnt_o", 32'd1, 32'(core_gnt_o));
        check_value("core_rvalid_o", 32'd0, 32'(core_rvalid_o));
        check_value("bus_req_o", 32'd0, 32'(bus_req_o));
        check_value("ext_gnt_o", 32'd0, 32'(ext_gnt_o));
        check_value("ext_rvalid_o", 32'd0, 32'(ext_rvalid_o));
        @(posedge clk_i);
        #1;
        end_test("Test 1 reset values", mark);

        // Full word first so no lane stays unwritten
        mark = errors;
        for (int i = 0; i < T2_N; i++) begin
            take_bits(11, a);
            a = a << 2;
            take_bits(32, d);
            core_access(1'b1, a, 4'hf, d);
            take_bits(32, d);
            take_bits(4, bmask);
            core_access(1'b1, a, bmask[3:0], d);
            core_access(1'b0, a, 4'hf, 32'h0);
        end
        wait_idle();
        end_test("Test 2 core SRAM writes and reads", mark);

        mark = errors;
        for (int i = 0; i < T3_N; i++) begin
            take_bits(16, a);
            a = BUS_BASE | (a << 2);
            take_bits(32, d);
            take_bits(4, bmask);
            take_bits(1, r);
            core_access(r[0], a, bmask[3:0], d);
        end
        wait_idle();
        end_test("Test 3 core bus accesses", mark);

        mark = errors;
        for (int i = 0; i < T4_N; i++) begin
            a = 32'(1024 + 4 * i);
            take_bits(32, d);
            ext_access(1'b1, a, 4'hf, d);
            core_access(1'b0, a, 4'hf, 32'h0);
            take_bits(32, d);
            take_bits(4, bmask);
            core_access(1'b1, a, bmask[3:0], d);
            wait_idle();
            ext_access(1'b0, a, 4'hf, 32'h0);
        end
        wait_idle();
        end_test("Test 4 shared SRAM between ports", mark);

        mark = errors;
        fork
            begin
                for (int i = 0; i < T5_N; i++) begin
                    core_access(1'b1, 32'(2048 + 4 * i), 4'hf, 32'hc0de_0000 + 32'(i));
                end
                for (int i = 0; i < T5_N; i++) begin
                    core_access(1'b0, 32'(2048 + 4 * i), 4'hf, 32'h0);
                end
            end
            begin
                // Core wins one round alone before the access port joins
                repeat (3) @(posedge clk_i);
                #1;
                for (int i = 0; i < T5_N; i++) begin
                    ext_access(1'b1, 32'(3072 + 4 * i), 4'hf, 32'he7e7_0000 + 32'(i));
                end
                for (int i = 0; i < T5_N; i++) begin
                    ext_access(1'b0, 32'(3072 + 4 * i), 4'hf, 32'h0);
                end
            end
        join
        wait_idle();
        end_test("Test 5 round-robin contention", mark);

        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

// ==== compile.f ====
verilog/core_data_pkg.sv
verilog/mem_req_if.sv
verilog/core_req_slot.sv
verilog/sram_arbiter.sv
verilog/data_memory.sv
verilog/core_data_top.sv
bench/tb_core_data_top.sv

// ==== run_sim.sh ====
#!/bin/sh
set -e

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing -j 0 --top-module tb_core_data_top -f compile.f

./obj_dir/Vtb_core_data_top > sim.log 2>&1
cat sim.log

grep -qx "TEST PASSED" sim.log
